// File: flist.f
+incdir+testbench
design/undo_pkg.sv
design/undo_log_capture.sv
design/undo_replay.sv
design/undo_log_top.sv
testbench/undo_log_props.sv
testbench/undo_log_tb.sv

// File: Bender.yml
package:
  name: undo_log

sources:
  - design/undo_pkg.sv
  - design/undo_log_capture.sv
  - design/undo_replay.sv
  - design/undo_log_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/undo_log_props.sv
      - testbench/undo_log_tb.sv

// File: testbench/undo_log_tests.svh
// ############################################################
// stimulus helpers and monitors
// ############################################################

task automatic step();
   @(posedge clk);
   #1;
endtask

task automatic apply_reset();
   rstn = 1'b0;
   repeat (2) @(posedge clk);
   #1;
   rstn         = 1'b1;
   busy         = '0;
   prev_done    = '0;
   done_stalled = '0;
   w_stalled    = 1'b0;
   b_taken      = 1'b0;
   mem_bvalid   = 1'b0;
   resp_id_q.delete();
   resp_due_q.delete();
   foreach (exp_last[s]) exp_last[s] = 0;  // the last-entry table clears on reset.
endtask

task automatic stage(input int core, input int slot, input int id);
   log_slot[core] = undo_pkg::slot_t'(slot);
   log_id[core]   = undo_pkg::entry_id_t'(id);
   log_addr[core] = $random(seed);
   log_data[core] = $random(seed);
endtask

// drives the staged cores together and expects the lowest one to win each cycle.
task automatic run_log(input logic [undo_pkg::N_CORES-1:0] mask);
   logic [undo_pkg::N_CORES-1:0] pend;
   int c;
   pend      = mask;
   log_valid = pend;
   while (pend != 0) begin
      #2;
      c = lowest_bit(pend);
      if (log_ready != (1 << c))
         flag_error($sformatf("log_ready %b while cores %b are valid", log_ready, pend));
      exp_addr[log_slot[c]][log_id[c]] = log_addr[c];
      exp_data[log_slot[c]][log_id[c]] = log_data[c];
      exp_last[log_slot[c]]            = log_id[c];
      pend[c] = 1'b0;
      step();
      log_valid = pend;
   end
endtask

task automatic fill_slot(input int slot, input int n);
   logic [undo_pkg::N_CORES-1:0] m;
   m = '0;
   for (int i = 0; i < n; i++) begin
      stage(i, slot, i);  // lower cores win first, so ids rise.
      m[i] = 1'b1;
   end
   run_log(m);
endtask

task automatic start_restore(input int slot, output int t);
   while (restore_req == 0) step();
   t        = lowest_bit(restore_req);
   free_now = ~busy;
   if (t != lowest_bit(free_now)) flag_error($sformatf("thread %0d offered, not the lowest", t));
   restore_grant  = restore_req;
   restore_slot   = undo_pkg::slot_t'(slot);
   exp_slot[t]    = slot;
   exp_count[t]   = exp_last[slot] + 1;
   wr_cnt[t]      = 0;
   resp_cnt[t]    = 0;
   grant_cycle[t] = cycle;
   busy[t]        = 1'b1;
   step();
   restore_grant = '0;
endtask

task automatic wait_idle();
   while (busy != 0 || resp_id_q.size() != 0 || mem_bvalid) step();
endtask

task automatic check_write();
   int t;
   int k;
   t = mem_wid;
   k = wr_cnt[t];
   n_writes++;
   if (!busy[t] || k >= exp_count[t]) begin
      flag_error($sformatf("unexpected write with id %0d", t));
   end else begin
      if (mem_waddr != exp_addr[exp_slot[t]][k] || mem_wdata != exp_data[exp_slot[t]][k])
         flag_error($sformatf("thread %0d entry %0d wrote %h/%h", t, k, mem_waddr, mem_wdata));
      if (!wready_random && cycle != grant_cycle[t] + 2 + 2 * k)
         flag_error($sformatf("thread %0d entry %0d written at the wrong cycle", t, k));
   end
   wr_cnt[t]++;
   resp_id_q.push_back(mem_wid);
   resp_due_q.push_back(cycle + 1 + ($unsigned($random(seed)) % 8));
endtask

// any due response may go next, so threads see their responses reordered.
task automatic pick_response();
   int due_idx [$];
   int k;
   foreach (resp_due_q[i]) begin
      if (resp_due_q[i] <= cycle) due_idx.push_back(i);
   end
   if (due_idx.size() > 0) begin
      k = due_idx[$unsigned($random(seed)) % due_idx.size()];
      mem_bvalid = 1'b1;
      mem_bid    = resp_id_q[k];
      resp_id_q.delete(k);
      resp_due_q.delete(k);
   end
endtask

task automatic check_done(input int t);
   if (done_stalled[t] && !restore_done_valid[t])
      flag_error($sformatf("done of thread %0d dropped before it was taken", t));
   if (restore_done_valid[t]) begin
      if (!busy[t]) flag_error($sformatf("done for idle thread %0d", t));
      if (restore_done_slot[t] != exp_slot[t])
         flag_error($sformatf("thread %0d done with slot %0d", t, restore_done_slot[t]));
      if (resp_cnt[t] != exp_count[t])
         flag_error($sformatf("thread %0d done after %0d responses", t, resp_cnt[t]));
      if (!prev_done[t] && cycle != last_resp_cycle[t] + 1)
         flag_error($sformatf("thread %0d done late after its last response", t));
      if (mem_bready) flag_error("mem_bready high while a done is pending");
      if (restore_done_ready[t]) begin
         busy[t] = 1'b0;
         n_dones++;
      end
   end
endtask

// ############################################################
// directed tests
// ############################################################

task automatic test_arbitration();
   stage(0, 0, 0);
   stage(1, 1, 0);
   stage(2, 4, 0);
   stage(3, 7, 0);
   run_log(4'b1111);
   stage(1, 1, 1);
   stage(3, 7, 1);
   run_log(4'b1010);
   stage(0, 0, 1);
   stage(2, 0, 2);
   run_log(4'b0101);
endtask

task automatic test_single_restore();
   int t;
   wready_random = 1'b0;
   fill_slot(2, 4);
   start_restore(2, t);
   wait_idle();
   if (wr_cnt[t] != 4) flag_error($sformatf("slot 2 restore made %0d writes", wr_cnt[t]));
endtask

task automatic test_write_backpressure();
   int t;
   wready_random = 1'b1;
   fill_slot(5, 4);
   start_restore(5, t);
   fill_slot(6, 3);  // logging goes on while the replay runs.
   start_restore(6, t);
   wait_idle();
   wready_random = 1'b0;
endtask

task automatic test_overlap();
   int t;
   wready_random = 1'b1;
   fill_slot(1, 3);
   fill_slot(3, 1);
   fill_slot(7, 4);
   start_restore(1, t);
   start_restore(3, t);
   start_restore(7, t);
   wait_idle();
   wready_random = 1'b0;
endtask

task automatic test_slot_rewrite();
   int t;
   fill_slot(2, 2);  // slot 2 held four records before.
   start_restore(2, t);
   wait_idle();
   if (wr_cnt[t] != 2) flag_error($sformatf("rewritten slot 2 made %0d writes", wr_cnt[t]));
endtask

task automatic test_done_backpressure();
   int t;
   restore_done_ready = '0;
   fill_slot(4, 2);
   start_restore(4, t);
   while (!restore_done_valid[t]) step();
   repeat (6) begin
      step();
      if (restore_done_valid != (1 << t) || mem_bready)
         flag_error("done or mem_bready changed while restore_done_ready was low");
      if (restore_req[t]) flag_error($sformatf("thread %0d offered while its done waits", t));
   end
   restore_done_ready = '1;
   step();
   step();
   if (!restore_req[t]) flag_error($sformatf("thread %0d not offered after release", t));
   // the reset below lands on a busy thread with its done still pending.
   restore_done_ready = '0;
   start_restore(4, t);
   while (!restore_done_valid[t]) step();
   apply_reset();
   if (mem_wvalid || restore_done_valid != 0 || !mem_bready || restore_req != 4'b0001)
      flag_error("outputs not in their idle state after reset");
endtask

// File: testbench/undo_log_tb.sv
module undo_log_tb;

   logic                                             clk;
   logic                                             rstn;
   logic                 [undo_pkg::N_CORES-1:0]     log_valid;
   logic                 [undo_pkg::N_CORES-1:0]     log_ready;
   undo_pkg::entry_id_t  [undo_pkg::N_CORES-1:0]     log_id;
   undo_pkg::undo_addr_t [undo_pkg::N_CORES-1:0]     log_addr;
   undo_pkg::undo_data_t [undo_pkg::N_CORES-1:0]     log_data;
   undo_pkg::slot_t      [undo_pkg::N_CORES-1:0]     log_slot;
   logic                 [undo_pkg::N_THREADS-1:0]   restore_req;
   logic                 [undo_pkg::N_THREADS-1:0]   restore_grant;
   undo_pkg::slot_t                                  restore_slot;
   logic                 [undo_pkg::N_THREADS-1:0]   restore_done_valid;
   logic                 [undo_pkg::N_THREADS-1:0]   restore_done_ready;
   undo_pkg::slot_t      [undo_pkg::N_THREADS-1:0]   restore_done_slot;
   logic                                             mem_wvalid;
   logic                                             mem_wready;
   undo_pkg::undo_addr_t                             mem_waddr;
   undo_pkg::undo_data_t                             mem_wdata;
   undo_pkg::thread_id_t                             mem_wid;
   logic                                             mem_bvalid;
   logic                                             mem_bready;
   undo_pkg::thread_id_t                             mem_bid;

   // ############################################################
   // scoreboard and memory model state
   // ############################################################

   undo_pkg::undo_addr_t exp_addr [undo_pkg::N_SLOTS][undo_pkg::N_ENTRIES];
   undo_pkg::undo_data_t exp_data [undo_pkg::N_SLOTS][undo_pkg::N_ENTRIES];
   int                   exp_last [undo_pkg::N_SLOTS];  // last logged id per slot.
   int                   exp_slot [undo_pkg::N_THREADS];
   int                   exp_count [undo_pkg::N_THREADS];
   int                   wr_cnt [undo_pkg::N_THREADS];
   int                   resp_cnt [undo_pkg::N_THREADS];
   int                   grant_cycle [undo_pkg::N_THREADS];
   int                   last_resp_cycle [undo_pkg::N_THREADS];
   logic [undo_pkg::N_THREADS-1:0] busy;  // threads granted and not yet done.
   logic [undo_pkg::N_THREADS-1:0] free_now;
   logic [undo_pkg::N_THREADS-1:0] prev_done;
   logic [undo_pkg::N_THREADS-1:0] done_stalled;
   undo_pkg::thread_id_t resp_id_q [$];
   int                   resp_due_q [$];
   logic                 wready_random;
   logic                 b_taken;
   logic                 w_stalled;
   undo_pkg::undo_addr_t held_addr;
   undo_pkg::undo_data_t held_data;
   undo_pkg::thread_id_t held_id;
   logic [31:0]          rnd;
   int                   seed;
   int                   cycle;
   int                   n_errors;
   int                   n_writes;
   int                   n_dones;

   undo_log_top dut (.*);

   always #4 clk = ~clk;

   task automatic flag_error(input string msg);
      n_errors++;
      $display("FAIL %0t: %s", $time, msg);
   endtask

   function automatic int lowest_bit(input logic [31:0] v);
      int r;
      r = -1;
      for (int i = 31; i >= 0; i--) begin
         if (v[i]) r = i;
      end
      return r;
   endfunction

   `include "undo_log_tests.svh"

   always @(posedge clk) begin
      cycle++;
      if (cycle >= 4000) begin
         $display("timeout: tests still running after %0d cycles", cycle);
         $display("Done: errors found");
         $finish;
      end
   end

   // memory port model, driven just after the edge.
   always @(posedge clk) begin
      #1;
      rnd = $random(seed);
      mem_wready = wready_random ? rnd[0] : 1'b1;
      if (b_taken || !mem_bvalid) begin
         mem_bvalid = 1'b0;
         b_taken    = 1'b0;
         pick_response();
      end
   end

   // handshakes are sampled mid-cycle, where every input and output is settled.
   always @(negedge clk) begin
      if (rstn) begin
         free_now = ~busy;
         if (restore_req != 0 && restore_req != (1 << lowest_bit(free_now)))
            flag_error($sformatf("restore_req %b with busy threads %b", restore_req, busy));
         if (w_stalled && !(mem_wvalid && mem_waddr == held_addr && mem_wdata == held_data &&
                            mem_wid == held_id))
            flag_error("a memory write changed before it was accepted");
         if (mem_wvalid && mem_wready) check_write();
         if (mem_bvalid && mem_bready) begin
            resp_cnt[mem_bid]++;
            last_resp_cycle[mem_bid] = cycle;
            b_taken = 1'b1;
            if (resp_cnt[mem_bid] > exp_count[mem_bid])
               flag_error($sformatf("too many responses for thread %0d", mem_bid));
         end
         for (int t = 0; t < undo_pkg::N_THREADS; t++) check_done(t);
         w_stalled    = mem_wvalid && !mem_wready;
         held_addr    = mem_waddr;
         held_data    = mem_wdata;
         held_id      = mem_wid;
         prev_done    = restore_done_valid;
         done_stalled = restore_done_valid & ~restore_done_ready;
      end
   end

   initial begin
      clk                = 1'b0;
      rstn               = 1'b0;
      log_valid          = '0;
      log_id             = '0;
      log_addr           = '0;
      log_data           = '0;
      log_slot           = '0;
      restore_grant      = '0;
      restore_slot       = '0;
      restore_done_ready = '1;
      mem_wready         = 1'b1;
      mem_bvalid         = 1'b0;
      mem_bid            = '0;
      seed               = 32'hc1f1_dbb3;
      cycle              = 0;
      n_errors           = 0;
      n_writes           = 0;
      n_dones            = 0;
      wready_random      = 1'b0;
      apply_reset();
      test_arbitration();
      test_single_restore();
      test_write_backpressure();
      test_overlap();
      test_slot_rewrite();
      test_done_backpressure();
      $display("writes %0d, restores done %0d, errors %0d", n_writes, n_dones, n_errors);
      if (n_errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

// File: testbench/undo_log_props.sv
module undo_log_props (
   input logic                                 clk,
   input logic                                 rstn,
   input logic [undo_pkg::N_THREADS-1:0]       restore_req,
   input logic [undo_pkg::N_THREADS-1:0]       restore_done_valid,
   input logic [undo_pkg::N_THREADS-1:0]       restore_done_ready,
   input logic                                 mem_wvalid,
   input logic                                 mem_wready,
   input undo_pkg::undo_addr_t                 mem_waddr,
   input undo_pkg::undo_data_t                 mem_wdata,
   input undo_pkg::thread_id_t                 mem_wid
);

   logic [undo_pkg::N_THREADS-1:0] done_wait;

   assign done_wait = restore_done_valid & ~restore_done_ready;

   // a write that is not taken keeps its address, data and id.
   a_write_held: assert property (@(posedge clk) disable iff (!rstn)
      mem_wvalid && !mem_wready |=>
         mem_wvalid && $stable(mem_waddr) && $stable(mem_wdata) && $stable(mem_wid))
      else $error("memory write changed before mem_wready");

   // one thread at most, never while a write runs and never one whose done waits.
   a_req_onehot: assert property (@(posedge clk) disable iff (!rstn)
      $onehot0(restore_req) && !(mem_wvalid && |restore_req) &&
         ((restore_req & restore_done_valid) == '0))
      else $error("restore_req offers more than one thread or a busy one");

   a_done_held: assert property (@(posedge clk) disable iff (!rstn)
      |done_wait |=> (restore_done_valid & $past(done_wait)) == $past(done_wait))
      else $error("restore done dropped before restore_done_ready");

endmodule

bind undo_log_top undo_log_props u_props (
   .clk                (clk),
   .rstn               (rstn),
   .restore_req        (restore_req),
   .restore_done_valid (restore_done_valid),
   .restore_done_ready (restore_done_ready),
   .mem_wvalid         (mem_wvalid),
   .mem_wready         (mem_wready),
   .mem_waddr          (mem_waddr),
   .mem_wdata          (mem_wdata),
   .mem_wid            (mem_wid)
);

// File: design/undo_log_top.sv
module undo_log_top (
   input  logic                                             clk,
   input  logic                                             rstn,

   // core log requests.
   input  logic                [undo_pkg::N_CORES-1:0]      log_valid,
   output logic                [undo_pkg::N_CORES-1:0]      log_ready,
   input  undo_pkg::entry_id_t [undo_pkg::N_CORES-1:0]      log_id,
   input  undo_pkg::undo_addr_t [undo_pkg::N_CORES-1:0]     log_addr,
   input  undo_pkg::undo_data_t [undo_pkg::N_CORES-1:0]     log_data,
   input  undo_pkg::slot_t     [undo_pkg::N_CORES-1:0]      log_slot,

   // conflict serializer.
   output logic                [undo_pkg::N_THREADS-1:0]    restore_req,
   input  logic                [undo_pkg::N_THREADS-1:0]    restore_grant,
   input  undo_pkg::slot_t                                  restore_slot,
   output logic                [undo_pkg::N_THREADS-1:0]    restore_done_valid,
   input  logic                [undo_pkg::N_THREADS-1:0]    restore_done_ready,
   output undo_pkg::slot_t     [undo_pkg::N_THREADS-1:0]    restore_done_slot,

   // memory writes.
   output logic                                             mem_wvalid,
   input  logic                                             mem_wready,
   output undo_pkg::undo_addr_t                             mem_waddr,
   output undo_pkg::undo_data_t                             mem_wdata,
   output undo_pkg::thread_id_t                             mem_wid,
   input  logic                                             mem_bvalid,
   output logic                                             mem_bready,
   input  undo_pkg::thread_id_t                             mem_bid
);

   undo_pkg::slot_t      rd_slot;
   undo_pkg::entry_id_t  rd_id;
   undo_pkg::undo_addr_t rd_addr;
   undo_pkg::undo_data_t rd_data;
   undo_pkg::slot_t      last_slot;
   undo_pkg::entry_id_t  last_id;

   undo_log_capture u_capture (
      .clk       (clk),
      .rstn      (rstn),
      .log_valid (log_valid),
      .log_ready (log_ready),
      .log_id    (log_id),
      .log_addr  (log_addr),
      .log_data  (log_data),
      .log_slot  (log_slot),
      .rd_slot   (rd_slot),
      .rd_id     (rd_id),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data),
      .last_slot (last_slot),
      .last_id   (last_id)
   );

   undo_replay u_replay (
      .clk                (clk),
      .rstn               (rstn),
      .restore_req        (restore_req),
      .restore_grant      (restore_grant),
      .restore_slot       (restore_slot),
      .restore_done_valid (restore_done_valid),
      .restore_done_ready (restore_done_ready),
      .restore_done_slot  (restore_done_slot),
      .rd_slot            (rd_slot),
      .rd_id              (rd_id),
      .rd_addr            (rd_addr),
      .rd_data            (rd_data),
      .last_slot          (last_slot),
      .last_id            (last_id),
      .mem_wvalid         (mem_wvalid),
      .mem_wready         (mem_wready),
      .mem_waddr          (mem_waddr),
      .mem_wdata          (mem_wdata),
      .mem_wid            (mem_wid),
      .mem_bvalid         (mem_bvalid),
      .mem_bready         (mem_bready),
      .mem_bid            (mem_bid)
   );

endmodule

// File: design/undo_replay.sv
module undo_replay (
   input  logic                                             clk,
   input  logic                                             rstn,

   // conflict serializer side.
   output logic                [undo_pkg::N_THREADS-1:0]    restore_req,
   input  logic                [undo_pkg::N_THREADS-1:0]    restore_grant,
   input  undo_pkg::slot_t                                  restore_slot,
   output logic                [undo_pkg::N_THREADS-1:0]    restore_done_valid,
   input  logic                [undo_pkg::N_THREADS-1:0]    restore_done_ready,
   output undo_pkg::slot_t     [undo_pkg::N_THREADS-1:0]    restore_done_slot,

   // log read port.
   output undo_pkg::slot_t                                  rd_slot,
   output undo_pkg::entry_id_t                              rd_id,
   input  undo_pkg::undo_addr_t                             rd_addr,
   input  undo_pkg::undo_data_t                             rd_data,
   output undo_pkg::slot_t                                  last_slot,
   input  undo_pkg::entry_id_t                              last_id,

   // memory write port.
   output logic                                             mem_wvalid,
   input  logic                                             mem_wready,
   output undo_pkg::undo_addr_t                             mem_waddr,
   output undo_pkg::undo_data_t                             mem_wdata,
   output undo_pkg::thread_id_t                             mem_wid,
   input  logic                                             mem_bvalid,
   output logic                                             mem_bready,
   input  undo_pkg::thread_id_t                             mem_bid
);

   typedef enum logic [1:0] {
      REPLAY_IDLE,
      REPLAY_READ_LOG,
      REPLAY_WRITE_MEM
   } replay_state_t;

   typedef enum logic {
      ACK_IDLE,
      ACK_DONE_PENDING
   } ack_state_t;

   replay_state_t replay_state;
   ack_state_t    ack_state;

   logic                 [undo_pkg::N_THREADS-1:0] in_use;
   undo_pkg::slot_t      [undo_pkg::N_THREADS-1:0] thread_slot;
   undo_pkg::remain_t    [undo_pkg::N_THREADS-1:0] remain;

   undo_pkg::thread_id_t free_thread;
   logic                 any_free;
   undo_pkg::thread_id_t grant_thread;
   logic                 grant_any;

   undo_pkg::thread_id_t cur_thread;
   undo_pkg::slot_t      cur_slot;
   undo_pkg::entry_id_t  cur_id;
   undo_pkg::thread_id_t ack_thread;

   logic take_grant;
   logic last_entry;
   logic resp_take;
   logic done_take;

   // ############################################################
   // thread allocation
   // ############################################################

   always_comb begin
      free_thread = '0;
      any_free    = 1'b0;
      for (int t = undo_pkg::N_THREADS - 1; t >= 0; t--) begin
         if (!in_use[t]) begin
            free_thread = undo_pkg::thread_id_t'(t);
            any_free    = 1'b1;
         end
      end
   end

   // the serializer only pulses the bit it was offered.
   always_comb begin
      grant_thread = '0;
      for (int t = undo_pkg::N_THREADS - 1; t >= 0; t--) begin
         if (restore_grant[t]) grant_thread = undo_pkg::thread_id_t'(t);
      end
   end

   assign grant_any  = |restore_grant;
   assign take_grant = (replay_state == REPLAY_IDLE) && grant_any;

   always_comb begin
      restore_req              = '0;
      restore_req[free_thread] = (replay_state == REPLAY_IDLE) && !grant_any && any_free;
   end

   always_ff @(posedge clk) begin
      if (take_grant) thread_slot[grant_thread] <= restore_slot;
   end

   // a grant and the last response never hit the same thread in one cycle.
   always_ff @(posedge clk) begin
      if (!rstn) begin
         in_use <= '0;
         remain <= '0;
      end else begin
         if (take_grant) begin
            in_use[grant_thread] <= 1'b1;
            remain[grant_thread] <= undo_pkg::remain_t'(last_id) + undo_pkg::remain_t'(1);
         end
         if (resp_take) remain[mem_bid] <= remain[mem_bid] - undo_pkg::remain_t'(1);
         if (done_take) in_use[ack_thread] <= 1'b0;  // free at the handshake edge.
      end
   end

   // ############################################################
   // replay sequencer
   // ############################################################

   // last_id is looked up for the incoming slot while idle.
   assign last_slot  = (replay_state == REPLAY_IDLE) ? restore_slot : cur_slot;
   assign last_entry = (cur_id == last_id);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         replay_state <= REPLAY_IDLE;
         cur_id       <= '0;
      end else begin
         case (replay_state)
            REPLAY_IDLE: begin
               if (take_grant) begin
                  replay_state <= REPLAY_READ_LOG;
                  cur_id       <= '0;
               end
            end
            REPLAY_READ_LOG: replay_state <= REPLAY_WRITE_MEM;  // read data lands here.
            REPLAY_WRITE_MEM: begin
               if (mem_wready) begin
                  if (last_entry) begin
                     replay_state <= REPLAY_IDLE;
                  end else begin
                     replay_state <= REPLAY_READ_LOG;
                     cur_id       <= cur_id + 1'b1;
                  end
               end
            end
            default: replay_state <= REPLAY_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (take_grant) begin
         cur_slot   <= restore_slot;
         cur_thread <= grant_thread;
      end
   end

   assign rd_slot = cur_slot;
   assign rd_id   = cur_id;

   // the read address holds during the write, so the fields stay stable.
   assign mem_wvalid = (replay_state == REPLAY_WRITE_MEM);
   assign mem_waddr  = rd_addr;
   assign mem_wdata  = rd_data;
   assign mem_wid    = cur_thread;

   // ############################################################
   // response counting
   // ############################################################

   assign resp_take = mem_bvalid && mem_bready;
   assign done_take = (ack_state == ACK_DONE_PENDING) && restore_done_ready[ack_thread];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         ack_state  <= ACK_IDLE;
         ack_thread <= '0;
      end else begin
         case (ack_state)
            ACK_IDLE: begin
               if (resp_take) begin
                  ack_thread <= mem_bid;
                  if (remain[mem_bid] == undo_pkg::remain_t'(1)) ack_state <= ACK_DONE_PENDING;
               end
            end
            ACK_DONE_PENDING: begin
               if (done_take) ack_state <= ACK_IDLE;
            end
            default: ack_state <= ACK_IDLE;
         endcase
      end
   end

   // responses stall while a done is waiting to be taken.
   assign mem_bready = (ack_state == ACK_IDLE);

   always_comb begin
      restore_done_valid             = '0;
      restore_done_valid[ack_thread] = (ack_state == ACK_DONE_PENDING);
   end

   assign restore_done_slot = thread_slot;

endmodule

// File: design/undo_log_capture.sv
module undo_log_capture (
   input  logic                                             clk,
   input  logic                                             rstn,

   // record input from the cores.
   input  logic                [undo_pkg::N_CORES-1:0]      log_valid,
   output logic                [undo_pkg::N_CORES-1:0]      log_ready,
   input  undo_pkg::entry_id_t [undo_pkg::N_CORES-1:0]      log_id,
   input  undo_pkg::undo_addr_t [undo_pkg::N_CORES-1:0]     log_addr,
   input  undo_pkg::undo_data_t [undo_pkg::N_CORES-1:0]     log_data,
   input  undo_pkg::slot_t     [undo_pkg::N_CORES-1:0]      log_slot,

   // read port toward the replay sequencer.
   input  undo_pkg::slot_t                                  rd_slot,
   input  undo_pkg::entry_id_t                              rd_id,
   output undo_pkg::undo_addr_t                             rd_addr,
   output undo_pkg::undo_data_t                             rd_data,
   input  undo_pkg::slot_t                                  last_slot,
   output undo_pkg::entry_id_t                              last_id
);

   typedef logic [undo_pkg::LOG_CORES-1:0] core_sel_t;
   typedef logic [undo_pkg::LOG_SLOTS+undo_pkg::LOG_ENTRIES-1:0] log_idx_t;

   core_sel_t            sel_core;
   logic                 sel_valid;
   undo_pkg::slot_t      sel_slot;
   undo_pkg::entry_id_t  sel_id;
   undo_pkg::undo_addr_t sel_addr;
   undo_pkg::undo_data_t sel_data;

   log_idx_t wr_idx;
   log_idx_t rd_idx;

   // one record per slot and entry id.
   undo_pkg::undo_addr_t addr_mem [undo_pkg::N_SLOTS*undo_pkg::N_ENTRIES];
   undo_pkg::undo_data_t data_mem [undo_pkg::N_SLOTS*undo_pkg::N_ENTRIES];

   undo_pkg::entry_id_t last_tab [undo_pkg::N_SLOTS];  // newest id logged per slot.

   // ############################################################
   // arbitration
   // ############################################################

   // the loop runs downward so the lowest valid core wins.
   always_comb begin
      sel_core  = '0;
      sel_valid = 1'b0;
      for (int c = undo_pkg::N_CORES - 1; c >= 0; c--) begin
         if (log_valid[c]) begin
            sel_core  = core_sel_t'(c);
            sel_valid = 1'b1;
         end
      end
   end

   always_comb begin
      sel_slot = log_slot[sel_core];
      sel_id   = log_id[sel_core];
      sel_addr = log_addr[sel_core];
      sel_data = log_data[sel_core];
   end

   // storage never stalls, so the winner is taken in the request cycle.
   always_comb begin
      log_ready           = '0;
      log_ready[sel_core] = sel_valid;
   end

   // ############################################################
   // storage
   // ############################################################

   assign wr_idx = {sel_slot, sel_id};
   assign rd_idx = {rd_slot, rd_id};

   always_ff @(posedge clk) begin
      if (sel_valid) begin
         addr_mem[wr_idx] <= sel_addr;
         data_mem[wr_idx] <= sel_data;
      end
      rd_addr <= addr_mem[rd_idx];  // one cycle read latency.
      rd_data <= data_mem[rd_idx];
   end

   // records come in increasing id, so the latest id is also the last one.
   // an id of 0 starts the slot over and shortens it.
   always_ff @(posedge clk) begin
      if (!rstn) begin
         last_tab <= '{default: '0};
      end else if (sel_valid) begin
         last_tab[sel_slot] <= sel_id;
      end
   end

   assign last_id = last_tab[last_slot];

endmodule

// File: design/undo_pkg.sv
package undo_pkg;

   // ############################################################
   // sizes of the undo log
   // ############################################################

   localparam int N_CORES     = 4;  // cores that log store-undo records.
   localparam int N_THREADS   = 4;  // restore threads working on aborted tasks.
   localparam int LOG_SLOTS   = 3;  // commit-queue slots, as log2.
   localparam int LOG_ENTRIES = 2;  // records per slot, as log2.

   localparam int N_SLOTS   = 2 ** LOG_SLOTS;
   localparam int N_ENTRIES = 2 ** LOG_ENTRIES;

   // index widths of the arbiter and the thread pickers.
   localparam int LOG_CORES   = $clog2(N_CORES);
   localparam int LOG_THREADS = $clog2(N_THREADS);

   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;

   // ############################################################
   // types
   // ############################################################

   // commit-queue slot of a task.
   typedef logic [LOG_SLOTS-1:0] slot_t;

   // record index within one slot.
   typedef logic [LOG_ENTRIES-1:0] entry_id_t;

   typedef logic [ADDR_W-1:0] undo_addr_t;  // address that the store changed.
   typedef logic [DATA_W-1:0] undo_data_t;  // word held there before the store.

   // restore thread index. the memory write id carries it as well.
   typedef logic [LOG_THREADS-1:0] thread_id_t;

   // outstanding write responses of one thread, up to N_ENTRIES.
   typedef logic [LOG_ENTRIES:0] remain_t;

endpackage
